// File: logic/sram_test_settings.svh
// ####################
// size settings for the memory test datapath
// chip count, shared data, address and mask widths
// ####################

`ifndef SRAM_TEST_SETTINGS_SVH
`define SRAM_TEST_SETTINGS_SVH

// number of srams in the bank
// one chip-select bit per chip on each port
`define SRAM_CHIPS 4

// shared data bus width
// narrow srams are zero-extended up to this
`define SRAM_DATA_W 32

// shared address width
// each sram only looks at its low bits
`define SRAM_ADDR_W 10

// byte write-mask bits on the read-write port
`define SRAM_MASK_W 4

`endif

// File: logic/sram_test_pkg.sv
// ####################
// shared types of the memory test datapath
// test mode enum, port request structs
// per-sram output struct and the bank-wide array
// ####################

`include "sram_test_settings.svh"

package sram_test_pkg;

   // test mode select, same encoding as the mode pins
   typedef enum logic [1:0] {
      MODE_LA   = 2'b00,
      MODE_GPIO = 2'b01,
      MODE_WB   = 2'b10,
      MODE_RRAM = 2'b11
   } test_mode_e;

   // read-write port request, shared by every chip
   typedef struct packed {
      // active low, one per chip
      logic [`SRAM_CHIPS-1:0]  csb;
      // active low write enable
      logic                    web;
      logic [`SRAM_MASK_W-1:0] wmask;
      logic [`SRAM_ADDR_W-1:0] addr;
      logic [`SRAM_DATA_W-1:0] din;
   } rw_req_t;

   // read-only port request
   typedef struct packed {
      logic [`SRAM_CHIPS-1:0]  csb;
      logic [`SRAM_ADDR_W-1:0] addr;
   } rd_req_t;

   // both outputs of one sram, zero-extended
   typedef struct packed {
      logic [`SRAM_DATA_W-1:0] data0;
      logic [`SRAM_DATA_W-1:0] data1;
   } sram_dout_t;

   // one entry per chip, index = chip number
   typedef sram_dout_t [`SRAM_CHIPS-1:0] sram_dout_arr_t;

endpackage

// File: logic/sram_1rw1r.sv
// ####################
// behavioural sram model
// port 0 read-write with optional byte mask
// port 1 read-only, present when HAS_RPORT is set
// ####################

`timescale 1ns/1ps

`include "sram_test_settings.svh"

module sram_1rw1r #(
   parameter int DATA_W    = 32,
   parameter int ADDR_W    = 10,
   parameter bit HAS_MASK  = 1'b1,
   parameter bit HAS_RPORT = 1'b1
) (
   input  logic                    clk,
   // port 0, read-write
   input  logic                    csb0_i,
   input  logic                    web0_i,
   input  logic [`SRAM_MASK_W-1:0] wmask0_i,
   input  logic [ADDR_W-1:0]       addr0_i,
   input  logic [DATA_W-1:0]       din0_i,
   output logic [DATA_W-1:0]       dout0_o,
   // port 1, read-only
   input  logic                    csb1_i,
   input  logic [ADDR_W-1:0]       addr1_i,
   output logic [DATA_W-1:0]       dout1_o
);

   localparam int LANES = DATA_W / 8;

   logic [DATA_W-1:0] mem [2**ADDR_W];
   // per-byte write enables
   logic [LANES-1:0]  lane_en;

   // no mask on this macro, every write is a full word
   if (HAS_MASK) begin : g_mask
      assign lane_en = wmask0_i[LANES-1:0];
   end else begin : g_nomask
      assign lane_en = '1;
   end

   // port 0: write enabled bytes, or register read data
   // dout0 holds across writes and idle cycles
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < LANES; b++) begin
               if (lane_en[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   if (HAS_RPORT) begin : g_rport
      // samples before the port 0 update lands, so a same-address
      // write in this cycle returns the old word
      always_ff @(posedge clk) begin
         if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
         end
      end
   end else begin : g_no_rport
      // single port macro
      assign dout1_o = '0;
   end

endmodule

// File: logic/sram_bank.sv
// ####################
// bank of four srams on shared request buses
// chip-select gating by the global chip select
// address slicing and output zero extension
// ####################

`timescale 1ns/1ps

`include "sram_test_settings.svh"

module sram_bank (
   input  logic                        clk,
   input  logic                        global_csb_i,
   input  sram_test_pkg::rw_req_t      rw_req_i,
   input  sram_test_pkg::rd_req_t      rd_req_i,
   output sram_test_pkg::sram_dout_arr_t dout_o
);

   // gated chip selects, high global csb idles every chip
   logic [`SRAM_CHIPS-1:0]  rw_csb;
   logic [`SRAM_CHIPS-1:0]  rd_csb;

   // raw macro outputs
   logic [7:0]              s0_dout0;
   logic [7:0]              s0_dout1;
   logic [`SRAM_DATA_W-1:0] s1_dout0;
   logic [`SRAM_DATA_W-1:0] s1_dout1;
   logic [`SRAM_DATA_W-1:0] s2_dout0;
   logic [`SRAM_DATA_W-1:0] s2_dout1;
   logic [`SRAM_DATA_W-1:0] s3_dout0;
   logic [`SRAM_DATA_W-1:0] s3_dout1;

   assign rw_csb = rw_req_i.csb | {`SRAM_CHIPS{global_csb_i}};
   assign rd_csb = rd_req_i.csb | {`SRAM_CHIPS{global_csb_i}};

   // sram0: 8 x 1024, no mask, only din[7:0] is stored
   sram_1rw1r #(.DATA_W(8), .ADDR_W(10), .HAS_MASK(1'b0), .HAS_RPORT(1'b1)) u_sram0 (
      .clk      (clk),
      .csb0_i   (rw_csb[0]),
      .web0_i   (rw_req_i.web),
      .wmask0_i (rw_req_i.wmask),
      .addr0_i  (rw_req_i.addr[9:0]),
      .din0_i   (rw_req_i.din[7:0]),
      .dout0_o  (s0_dout0),
      .csb1_i   (rd_csb[0]),
      .addr1_i  (rd_req_i.addr[9:0]),
      .dout1_o  (s0_dout1)
   );

   // sram1: 32 x 256, byte mask
   sram_1rw1r #(.DATA_W(32), .ADDR_W(8), .HAS_MASK(1'b1), .HAS_RPORT(1'b1)) u_sram1 (
      .clk      (clk),
      .csb0_i   (rw_csb[1]),
      .web0_i   (rw_req_i.web),
      .wmask0_i (rw_req_i.wmask),
      .addr0_i  (rw_req_i.addr[7:0]),
      .din0_i   (rw_req_i.din),
      .dout0_o  (s1_dout0),
      .csb1_i   (rd_csb[1]),
      .addr1_i  (rd_req_i.addr[7:0]),
      .dout1_o  (s1_dout1)
   );

   // sram2: 32 x 512, byte mask
   sram_1rw1r #(.DATA_W(32), .ADDR_W(9), .HAS_MASK(1'b1), .HAS_RPORT(1'b1)) u_sram2 (
      .clk      (clk),
      .csb0_i   (rw_csb[2]),
      .web0_i   (rw_req_i.web),
      .wmask0_i (rw_req_i.wmask),
      .addr0_i  (rw_req_i.addr[8:0]),
      .din0_i   (rw_req_i.din),
      .dout0_o  (s2_dout0),
      .csb1_i   (rd_csb[2]),
      .addr1_i  (rd_req_i.addr[8:0]),
      .dout1_o  (s2_dout1)
   );

   // sram3: 32 x 256 single port, port 1 inputs are ignored inside
   sram_1rw1r #(.DATA_W(32), .ADDR_W(8), .HAS_MASK(1'b1), .HAS_RPORT(1'b0)) u_sram3 (
      .clk      (clk),
      .csb0_i   (rw_csb[3]),
      .web0_i   (rw_req_i.web),
      .wmask0_i (rw_req_i.wmask),
      .addr0_i  (rw_req_i.addr[7:0]),
      .din0_i   (rw_req_i.din),
      .dout0_o  (s3_dout0),
      .csb1_i   (rd_csb[3]),
      .addr1_i  (rd_req_i.addr[7:0]),
      .dout1_o  (s3_dout1)
   );

   // pack into the shared array, sram0 zero-extended
   always_comb begin
      dout_o[0].data0 = {{(`SRAM_DATA_W-8){1'b0}}, s0_dout0};
      dout_o[0].data1 = {{(`SRAM_DATA_W-8){1'b0}}, s0_dout1};
      dout_o[1].data0 = s1_dout0;
      dout_o[1].data1 = s1_dout1;
      dout_o[2].data0 = s2_dout0;
      dout_o[2].data1 = s2_dout1;
      dout_o[3].data0 = s3_dout0;
      dout_o[3].data1 = s3_dout1;
   end

endmodule

// File: logic/mode_ctrl.sv
// ####################
// test mode decoder
// picks soft reset and global chip select
// registered outputs, idle after reset
// ####################

`timescale 1ns/1ps

module mode_ctrl (
   input  logic                     clk,
   input  logic                     rstn,
   input  sram_test_pkg::test_mode_e mode_i,
   input  logic                     la_reset_i,
   input  logic                     la_global_cs_i,
   input  logic                     gpio_resetn_i,
   input  logic                     gpio_global_csb_i,
   output logic                     soft_rstn_o,
   output logic                     global_csb_o
);

   import sram_test_pkg::*;

   logic soft_rstn_sel;
   logic global_csb_sel;

   // la pins are active high, gpio pins active low
   always_comb begin
      case (mode_i)
         MODE_LA: begin
            soft_rstn_sel  = ~la_reset_i;
            global_csb_sel = ~la_global_cs_i;
         end
         MODE_GPIO: begin
            soft_rstn_sel  = gpio_resetn_i;
            global_csb_sel = gpio_global_csb_i;
         end
         // wb and rram modes leave the bank idle
         default: begin
            soft_rstn_sel  = 1'b1;
            global_csb_sel = 1'b1;
         end
      endcase
   end

   // one cycle of latency, keeps pin glitches off the bank
   always_ff @(posedge clk) begin
      if (!rstn) begin
         soft_rstn_o  <= 1'b1;
         global_csb_o <= 1'b1;
      end else begin
         soft_rstn_o  <= soft_rstn_sel;
         global_csb_o <= global_csb_sel;
      end
   end

endmodule

// File: logic/capture_regs.sv
// ####################
// capture stage for all sram outputs
// cleared by rstn or the soft reset
// ####################

`timescale 1ns/1ps

module capture_regs (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          soft_rstn_i,
   input  sram_test_pkg::sram_dout_arr_t dout_i,
   output sram_test_pkg::sram_dout_arr_t capture_o
);

   // either reset source clears the whole array
   // otherwise sample both ports of every chip each cycle
   always_ff @(posedge clk) begin
      if (!rstn || !soft_rstn_i) begin
         capture_o <= '0;
      end else begin
         capture_o <= dout_i;
      end
   end

endmodule

// File: logic/openram_test_top.sv
// ####################
// memory test datapath top level
// mode control, sram bank, capture stage
// ####################

`timescale 1ns/1ps

module openram_test_top (
   input  logic                          clk,
   input  logic                          rstn,
   input  sram_test_pkg::test_mode_e     mode_i,
   // la pins, active high
   input  logic                          la_reset_i,
   input  logic                          la_global_cs_i,
   // gpio pins, active low
   input  logic                          gpio_resetn_i,
   input  logic                          gpio_global_csb_i,
   // shared port requests
   input  sram_test_pkg::rw_req_t        rw_req_i,
   input  sram_test_pkg::rd_req_t        rd_req_i,
   output sram_test_pkg::sram_dout_arr_t capture_o
);

   import sram_test_pkg::*;

   logic           soft_rstn;
   logic           global_csb;
   sram_dout_arr_t dout;

   mode_ctrl u_mode_ctrl (
      .clk               (clk),
      .rstn              (rstn),
      .mode_i            (mode_i),
      .la_reset_i        (la_reset_i),
      .la_global_cs_i    (la_global_cs_i),
      .gpio_resetn_i     (gpio_resetn_i),
      .gpio_global_csb_i (gpio_global_csb_i),
      .soft_rstn_o       (soft_rstn),
      .global_csb_o      (global_csb)
   );

   sram_bank u_sram_bank (
      .clk          (clk),
      .global_csb_i (global_csb),
      .rw_req_i     (rw_req_i),
      .rd_req_i     (rd_req_i),
      .dout_o       (dout)
   );

   // read data lands here one edge after the bank
   capture_regs u_capture_regs (
      .clk         (clk),
      .rstn        (rstn),
      .soft_rstn_i (soft_rstn),
      .dout_i      (dout),
      .capture_o   (capture_o)
   );

endmodule

// File: tb/openram_test_chk.sv
// ####################
// concurrent assertions on the top level
// reset clear, idle modes, sram3 port 1
// ####################

`timescale 1ns/1ps

module openram_test_chk (
   input logic                          clk,
   input logic                          rstn,
   input sram_test_pkg::test_mode_e     mode_i,
   input logic                          global_csb_i,
   input sram_test_pkg::sram_dout_arr_t capture_i
);

   import sram_test_pkg::*;

   // a reset edge clears every captured word
   a_rst_clear: assert property (@(posedge clk) !rstn |=> capture_i == '0)
      else $error("capture_o not cleared after a reset edge");

   // wb and rram park the bank one cycle later
   a_idle_mode: assert property (@(posedge clk)
      (mode_i == MODE_WB || mode_i == MODE_RRAM) |=> global_csb_i)
      else $error("global chip select low in an idle mode");

   // sram3 is single port
   a_sram3_d1: assert property (@(posedge clk) disable iff (!rstn) capture_i[3].data1 == '0)
      else $error("sram3 data1 not zero");

endmodule

bind openram_test_top openram_test_chk u_chk (
   .clk          (clk),
   .rstn         (rstn),
   .mode_i       (mode_i),
   .global_csb_i (global_csb),
   .capture_i    (capture_o)
);

// File: tb/openram_test_tb.sv
// ####################
// testbench for the memory test datapath
// stimulus table, sram reference model
// capture checks, cycle timeout, summary line
// ####################

`timescale 1ns/1ps

module openram_test_tb;

   import sram_test_pkg::*;

   typedef enum logic [2:0] {OP_IDLE, OP_WR, OP_RD0, OP_RD1, OP_WRRD1} op_e;

   // one table row, exp/chk/clr come from the reference model
   typedef struct packed {
      test_mode_e  mode;
      logic        la_rst;
      logic        la_cs;
      logic        g_rstn;
      logic        g_csb;
      logic [1:0]  chip;
      op_e         op;
      logic [3:0]  mask;
      logic [9:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic        chk;
      logic        clr;
   } row_t;

   // pin sets as {la_reset, la_global_cs, gpio_resetn, gpio_global_csb}
   localparam logic [3:0] PINS_GPIO     = 4'b0010;
   localparam logic [3:0] PINS_GPIO_RST = 4'b0000;
   localparam logic [3:0] PINS_LA       = 4'b0111;
   localparam logic [3:0] PINS_LA_OFF   = 4'b0010;
   localparam logic [3:0] PINS_LA_RST   = 4'b1111;
   localparam logic [3:0] PINS_ALL_ON   = 4'b1100;

   logic           clk;
   logic           rstn;
   test_mode_e     mode;
   logic           la_reset;
   logic           la_global_cs;
   logic           gpio_resetn;
   logic           gpio_global_csb;
   rw_req_t        rw_req;
   rd_req_t        rd_req;
   sram_dout_arr_t capture;

   row_t        tbl [$];
   // reference memories, one per sram
   logic [7:0]  ref0 [1024];
   logic [31:0] ref1 [256];
   logic [31:0] ref2 [512];
   logic [31:0] ref3 [256];
   // home address per chip, high bits set to show truncation
   logic [9:0]  wa [4] = '{10'h3a5, 10'h2c3, 10'h1f0, 10'h35a};
   logic [31:0] lcg_state = 32'h142d;
   int          n_checks = 0;
   int          n_errors = 0;
   int          cycles = 0;
   int          cycle_limit = 1000;

   openram_test_top uut (
      .clk               (clk),
      .rstn              (rstn),
      .mode_i            (mode),
      .la_reset_i        (la_reset),
      .la_global_cs_i    (la_global_cs),
      .gpio_resetn_i     (gpio_resetn),
      .gpio_global_csb_i (gpio_global_csb),
      .rw_req_i          (rw_req),
      .rd_req_i          (rd_req),
      .capture_o         (capture)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [3:0] mask,
                                               input logic [31:0] data);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (mask[b]) begin
            res[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // each sram sees only the low address bits
   function automatic logic [31:0] mem_read(input logic [1:0] chip, input logic [9:0] addr);
      case (chip)
         2'd0:    return {24'h0, ref0[addr]};
         2'd1:    return ref1[addr[7:0]];
         2'd2:    return ref2[addr[8:0]];
         default: return ref3[addr[7:0]];
      endcase
   endfunction

   task automatic mem_write(input logic [1:0] chip, input logic [9:0] addr,
                            input logic [3:0] mask, input logic [31:0] data);
      case (chip)
         // sram0 has no mask, keeps the low byte
         2'd0:    ref0[addr] = data[7:0];
         2'd1:    ref1[addr[7:0]] = merge_bytes(ref1[addr[7:0]], mask, data);
         2'd2:    ref2[addr[8:0]] = merge_bytes(ref2[addr[8:0]], mask, data);
         default: ref3[addr[7:0]] = merge_bytes(ref3[addr[7:0]], mask, data);
      endcase
   endtask

   // {soft_rstn, global_csb} selected by the mode
   function automatic logic [1:0] decode_pins(input row_t r);
      case (r.mode)
         MODE_LA:   return {~r.la_rst, ~r.la_cs};
         MODE_GPIO: return {r.g_rstn, r.g_csb};
         default:   return 2'b11;
      endcase
   endfunction

   task automatic add_row(input test_mode_e md, input logic [3:0] pins, input int chip,
                          input op_e op, input logic [3:0] mask, input logic [9:0] addr,
                          input logic [31:0] data);
      row_t r;
      r = '0;
      r.mode = md;
      {r.la_rst, r.la_cs, r.g_rstn, r.g_csb} = pins;
      r.chip = chip[1:0];
      r.op = op;
      r.mask = mask;
      r.addr = addr;
      r.data = data;
      tbl.push_back(r);
   endtask

   task automatic build_table();
      // first row still sees the idle chip select from reset
      add_row(MODE_GPIO, PINS_GPIO, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      // full writes and port 0 readback
      for (int c = 0; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_WR, 4'hf, wa[c], lcg_next());
      for (int c = 0; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_RD0, 4'h0, wa[c], 32'h0);
      // alias of 10'h2c3 on the 256 word sram1
      add_row(MODE_GPIO, PINS_GPIO, 1, OP_RD0, 4'h0, 10'h0c3, 32'h0);
      // partial byte writes
      for (int c = 1; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_WR, 4'b0101, wa[c], 32'h1234_5678);
      for (int c = 1; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_RD0, 4'h0, wa[c], 32'h0);
      add_row(MODE_GPIO, PINS_GPIO, 2, OP_WR, 4'b1000, wa[2], lcg_next());
      add_row(MODE_GPIO, PINS_GPIO, 2, OP_RD0, 4'h0, wa[2], 32'h0);
      // read-only port, sram3 has none
      for (int c = 0; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_RD1, 4'h0, wa[c], 32'h0);
      for (int c = 0; c < 3; c++) begin
         add_row(MODE_GPIO, PINS_GPIO, c, OP_WRRD1, 4'hf, wa[c], lcg_next());
         add_row(MODE_GPIO, PINS_GPIO, c, OP_RD1, 4'h0, wa[c], 32'h0);
         add_row(MODE_GPIO, PINS_GPIO, c, OP_RD0, 4'h0, wa[c], 32'h0);
      end
      // la mode with chip select off, writes dropped
      add_row(MODE_LA, PINS_LA_OFF, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_row(MODE_LA, PINS_LA_OFF, c, OP_WR, 4'hf, wa[c], lcg_next());
      add_row(MODE_LA, PINS_LA, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_row(MODE_LA, PINS_LA, c, OP_RD0, 4'h0, wa[c], 32'h0);
      // soft reset from la, then from gpio
      add_row(MODE_LA, PINS_LA_RST, 1, OP_RD0, 4'h0, wa[1], 32'h0);
      add_row(MODE_LA, PINS_LA_RST, 2, OP_RD0, 4'h0, wa[2], 32'h0);
      add_row(MODE_LA, PINS_LA, 0, OP_RD0, 4'h0, wa[0], 32'h0);
      add_row(MODE_GPIO, PINS_GPIO_RST, 3, OP_RD0, 4'h0, wa[3], 32'h0);
      add_row(MODE_GPIO, PINS_GPIO_RST, 2, OP_RD1, 4'h0, wa[2], 32'h0);
      add_row(MODE_GPIO, PINS_GPIO, 3, OP_RD0, 4'h0, wa[3], 32'h0);
      // wb and rram keep the bank idle whatever the pins say
      add_row(MODE_WB, PINS_ALL_ON, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_row(MODE_WB, PINS_ALL_ON, c, OP_WR, 4'hf, wa[c], lcg_next());
      for (int c = 0; c < 4; c++) add_row(MODE_WB, PINS_ALL_ON, c, OP_RD0, 4'h0, 10'h0, 32'h0);
      add_row(MODE_RRAM, PINS_ALL_ON, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_row(MODE_RRAM, PINS_ALL_ON, c, OP_WR, 4'hf, wa[c], lcg_next());
      for (int c = 0; c < 3; c++) add_row(MODE_RRAM, PINS_ALL_ON, c, OP_RD1, 4'h0, 10'h0, 32'h0);
      add_row(MODE_GPIO, PINS_GPIO, 0, OP_IDLE, 4'h0, 10'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_row(MODE_GPIO, PINS_GPIO, c, OP_RD0, 4'h0, wa[c], 32'h0);
   endtask

   // walk the table in order, chip select lags the pins by one row
   task automatic fill_expected();
      row_t        r;
      logic        gcsb_prev;
      logic [1:0]  dec;
      logic [31:0] dout_m [4][2];
      gcsb_prev = 1'b1;
      for (int c = 0; c < 4; c++) begin
         dout_m[c][0] = 32'h0;
         dout_m[c][1] = 32'h0;
      end
      for (int k = 0; k < tbl.size(); k++) begin
         r = tbl[k];
         if (!gcsb_prev) begin
            case (r.op)
               OP_WR:  mem_write(r.chip, r.addr, r.mask, r.data);
               OP_RD0: dout_m[r.chip][0] = mem_read(r.chip, r.addr);
               OP_RD1: begin
                  if (r.chip != 2'd3) dout_m[r.chip][1] = mem_read(r.chip, r.addr);
               end
               OP_WRRD1: begin
                  // port 1 returns the word from before the write
                  if (r.chip != 2'd3) dout_m[r.chip][1] = mem_read(r.chip, r.addr);
                  mem_write(r.chip, r.addr, r.mask, r.data);
               end
               default: ;
            endcase
         end
         dec = decode_pins(r);
         r.clr = ~dec[1];
         r.chk = (r.op == OP_RD0 || r.op == OP_RD1 || r.op == OP_WRRD1);
         r.exp = (r.op == OP_RD0) ? dout_m[r.chip][0] : dout_m[r.chip][1];
         gcsb_prev = dec[0];
         tbl[k] = r;
      end
   endtask

   task automatic apply_row(input row_t r);
      rw_req_t rw;
      rd_req_t rd;
      rw = '0;
      rw.csb = '1;
      rw.web = 1'b1;
      rw.wmask = r.mask;
      rw.addr = r.addr;
      rw.din = r.data;
      rd = '0;
      rd.csb = '1;
      rd.addr = r.addr;
      if (r.op == OP_WR || r.op == OP_RD0 || r.op == OP_WRRD1) rw.csb[r.chip] = 1'b0;
      if (r.op == OP_WR || r.op == OP_WRRD1) rw.web = 1'b0;
      if (r.op == OP_RD1 || r.op == OP_WRRD1) rd.csb[r.chip] = 1'b0;
      mode <= r.mode;
      la_reset <= r.la_rst;
      la_global_cs <= r.la_cs;
      gpio_resetn <= r.g_rstn;
      gpio_global_csb <= r.g_csb;
      rw_req <= rw;
      rd_req <= rd;
   endtask

   task automatic check_val(input string name, input logic [255:0] exp, input logic [255:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
      end
   endtask

   task automatic check_row(input row_t r);
      int          port;
      logic [31:0] act;
      port = (r.op == OP_RD0) ? 0 : 1;
      act = (port == 0) ? capture[r.chip].data0 : capture[r.chip].data1;
      if (r.clr) begin
         check_val("capture_o", '0, capture);
      end else if (r.chk) begin
         check_val($sformatf("capture_o[%0d].data%0d", r.chip, port), 256'(r.exp), 256'(act));
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycle_limit);
         $display("Errors found");
         $finish;
      end
   end

   initial begin
      row_t idle;
      idle = '0;
      idle.mode = MODE_WB;
      rstn <= 1'b0;
      apply_row(idle);
      build_table();
      fill_expected();
      cycle_limit = tbl.size() + 20;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      // trailing rows only flush the last reads
      idle = tbl[tbl.size()-1];
      idle.op = OP_IDLE;
      for (int i = 0; i < tbl.size() + 2; i++) begin
         @(posedge clk);
         if (i < tbl.size()) apply_row(tbl[i]);
         else apply_row(idle);
         // read data reaches capture_o two edges after the request
         @(negedge clk);
         if (i >= 2) check_row(tbl[i-2]);
      end
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+logic
logic/sram_test_pkg.sv
logic/sram_1rw1r.sv
logic/sram_bank.sv
logic/mode_ctrl.sv
logic/capture_regs.sv
logic/openram_test_top.sv
tb/openram_test_chk.sv
tb/openram_test_tb.sv

// File: Makefile
# Verilator build and run for the memory test datapath
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module openram_test_tb

run: build
	./obj_dir/Vopenram_test_tb | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only --timing -f all.f --top-module openram_test_tb

clean:
	rm -rf obj_dir $(LOG)
